// File: common/tlp_pkg.sv
/* TLP beat layout shared by the TX pipeline and its testbench.
   Import it wherever headers are decoded or commit beats are built */
package tlp_pkg;

    // One stream beat carries 64 bits of header or payload
    localparam int TLP_DATA_W = 64;
    localparam int TLP_OP_W = 8;
    localparam int TLP_TAG_W = 8;

    // Opcode sits in the top byte of the first beat of every packet
    localparam int HDR_OP_MSB = 63;
    localparam int HDR_OP_LSB = 56;

    // Tag follows the opcode and is echoed back in the commit
    localparam int HDR_TAG_MSB = 55;
    localparam int HDR_TAG_LSB = 48;

    // The remaining header bits hold the address
    localparam int HDR_ADDR_MSB = 47;
    localparam int HDR_ADDR_LSB = 0;

    typedef enum logic [TLP_OP_W-1:0]
    {
        OP_MEM_RD = 8'h00,
        OP_MEM_WR = 8'h40,
        OP_CPL    = 8'h4a,
        OP_COMMIT = 8'hf0
    } tlp_op_e;

    // Builds the single-beat local commit that answers a write header
    function automatic logic [TLP_DATA_W-1:0] commit_beat(input logic [TLP_TAG_W-1:0] tag);
        logic [TLP_DATA_W-1:0] beat;
        beat = '0;
        beat[HDR_OP_MSB:HDR_OP_LSB] = OP_COMMIT;
        beat[HDR_TAG_MSB:HDR_TAG_LSB] = tag;
        // A commit has no address, so the field is left at zero
        beat[HDR_ADDR_MSB:HDR_ADDR_LSB] = '0;
        return beat;
    endfunction

endpackage

// File: common/emul_cfg_pkg.sv
/* Sizing constants and FSM encodings of the emulated PCIe TX port */
package emul_cfg_pkg;

    // Arbiter is either at a packet boundary or locked onto one input
    typedef enum logic [1:0]
    {
        ARB_IDLE,
        ARB_HOLD_A,
        ARB_HOLD_B
    } arb_state_e;

    // Number of commit beats that may wait for the RX B port
    localparam int COMMIT_FIFO_DEPTH = 4;

    // Occupancy count must reach COMMIT_FIFO_DEPTH itself
    localparam int COMMIT_CNT_W = 3;

    // Read and write pointers wrap naturally over the depth
    localparam int COMMIT_PTR_W = 2;

endpackage

// File: local_commit/commit_fifo.sv
/* Circular queue of write tags waiting to leave as commit beats.
   The head entry is presented as a one-beat OP_COMMIT packet */
module commit_fifo
(
    input  logic                            afu_csr_axi_lite_if,
    input  logic                            rst,

    input  logic                            push,
    input  logic [tlp_pkg::TLP_TAG_W-1:0]   push_tag,
    output logic                            full,

    output logic                            commit_valid,
    input  logic                            commit_ready,
    output logic [tlp_pkg::TLP_DATA_W-1:0]  commit_data,
    output logic                            commit_last
);
    import tlp_pkg::*;
    import emul_cfg_pkg::*;

    // Only the tag is stored since the rest of a commit is constant
    logic [TLP_TAG_W-1:0] tag_mem [COMMIT_FIFO_DEPTH];
    logic [COMMIT_PTR_W-1:0] wr_ptr;
    logic [COMMIT_PTR_W-1:0] rd_ptr;
    logic [COMMIT_CNT_W-1:0] count;
    logic pop;

    assign full = (count == COMMIT_CNT_W'(COMMIT_FIFO_DEPTH));
    assign commit_valid = (count != '0);
    assign pop = commit_valid && commit_ready;

    // Head tag expands into the full commit beat
    assign commit_data = commit_beat(tag_mem[rd_ptr]);
    assign commit_last = 1'b1;

    always_ff @(posedge afu_csr_axi_lite_if)
    begin
        if (push)
            tag_mem[wr_ptr] <= push_tag;
    end

    always_ff @(posedge afu_csr_axi_lite_if)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            // Pointers wrap on their own at the power-of-two depth
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + COMMIT_CNT_W'(push) - COMMIT_CNT_W'(pop);
        end
    end

    a_cnt_max: assert property (@(posedge afu_csr_axi_lite_if) disable iff (rst)
        count <= COMMIT_CNT_W'(COMMIT_FIFO_DEPTH));

endmodule

// File: local_commit/local_commit.sv
/* Passes the merged TX stream on to the host port and queues one commit
   beat on the RX B commit port for every memory-write packet */
module local_commit
(
    input  logic                            afu_csr_axi_lite_if,
    input  logic                            rst,

    input  logic                            arb_valid,
    output logic                            arb_ready,
    input  logic [tlp_pkg::TLP_DATA_W-1:0]  arb_data,
    input  logic                            arb_last,

    output logic                            host_tx_valid,
    input  logic                            host_tx_ready,
    output logic [tlp_pkg::TLP_DATA_W-1:0]  host_tx_data,
    output logic                            host_tx_last,

    output logic                            commit_valid,
    input  logic                            commit_ready,
    output logic [tlp_pkg::TLP_DATA_W-1:0]  commit_data,
    output logic                            commit_last
);
    import tlp_pkg::*;

    // High while the next beat on arb starts a new packet
    logic first_beat;
    tlp_op_e hdr_op;
    logic is_wr_hdr;
    logic host_can_load;
    logic take;
    logic push;
    logic [TLP_TAG_W-1:0] push_tag;
    logic fifo_full;

    // Header fields are only meaningful on the first beat
    assign hdr_op = tlp_op_e'(arb_data[HDR_OP_MSB:HDR_OP_LSB]);
    assign push_tag = arb_data[HDR_TAG_MSB:HDR_TAG_LSB];
    assign is_wr_hdr = first_beat && (hdr_op == OP_MEM_WR);

    // Host register refills in the same cycle it drains
    assign host_can_load = !host_tx_valid || host_tx_ready;

    // A write header waits for FIFO space; payload beats never do
    assign arb_ready = host_can_load && !(is_wr_hdr && fifo_full);
    assign take = arb_valid && arb_ready;
    assign push = take && is_wr_hdr;

    always_ff @(posedge afu_csr_axi_lite_if)
    begin
        if (rst)
            first_beat <= 1'b1;
        else if (take)
            first_beat <= arb_last;
    end

    always_ff @(posedge afu_csr_axi_lite_if)
    begin
        if (rst)
            host_tx_valid <= 1'b0;
        else if (take)
            host_tx_valid <= 1'b1;
        else if (host_tx_ready)
            host_tx_valid <= 1'b0;
    end

    always_ff @(posedge afu_csr_axi_lite_if)
    begin
        if (take)
        begin
            host_tx_data <= arb_data;
            host_tx_last <= arb_last;
        end
    end

    // Commits leave in write-header order through a small queue
    commit_fifo u_commit_fifo
    (
        .afu_csr_axi_lite_if (afu_csr_axi_lite_if),
        .rst                 (rst),
        .push                (push),
        .push_tag            (push_tag),
        .full                (fifo_full),
        .commit_valid        (commit_valid),
        .commit_ready        (commit_ready),
        .commit_data         (commit_data),
        .commit_last         (commit_last)
    );

    // The header stall must keep every push inside the FIFO capacity
    a_no_push_full: assert property (@(posedge afu_csr_axi_lite_if) disable iff (rst)
        push |-> !fifo_full);

endmodule

// File: logic/tx_ab_arbiter.sv
/* Merges the TX A and TX B TLP streams into one registered stream.
   Packets are never interleaved and inputs alternate at packet boundaries */
module tx_ab_arbiter
(
    input  logic                            afu_csr_axi_lite_if,
    input  logic                            rst,

    input  logic                            tx_a_valid,
    output logic                            tx_a_ready,
    input  logic [tlp_pkg::TLP_DATA_W-1:0]  tx_a_data,
    input  logic                            tx_a_last,

    input  logic                            tx_b_valid,
    output logic                            tx_b_ready,
    input  logic [tlp_pkg::TLP_DATA_W-1:0]  tx_b_data,
    input  logic                            tx_b_last,

    output logic                            arb_valid,
    input  logic                            arb_ready,
    output logic [tlp_pkg::TLP_DATA_W-1:0]  arb_data,
    output logic                            arb_last
);
    import emul_cfg_pkg::*;

    arb_state_e state;
    // Set when B won the most recent boundary, so A goes first after reset
    logic b_won_last;
    logic out_ready;
    logic sel_a;
    logic sel_b;
    logic take_a;
    logic take_b;

    // Output register can take a beat when empty or draining this cycle
    assign out_ready = !arb_valid || arb_ready;

    // At a boundary the input that lost last time wins a tie
    always_comb
    begin
        sel_a = 1'b0;
        sel_b = 1'b0;
        case (state)
            ARB_HOLD_A: sel_a = 1'b1;
            ARB_HOLD_B: sel_b = 1'b1;
            default:
            begin
                sel_a = tx_a_valid && (!tx_b_valid || b_won_last);
                sel_b = tx_b_valid && !sel_a;
            end
        endcase
    end

    assign tx_a_ready = out_ready && sel_a;
    assign tx_b_ready = out_ready && sel_b;
    assign take_a = tx_a_valid && tx_a_ready;
    assign take_b = tx_b_valid && tx_b_ready;

    // Lock onto the winner until its last beat is accepted
    always_ff @(posedge afu_csr_axi_lite_if)
    begin
        if (rst)
        begin
            state <= ARB_IDLE;
            b_won_last <= 1'b1;
        end
        else if (take_a)
        begin
            state <= tx_a_last ? ARB_IDLE : ARB_HOLD_A;
            b_won_last <= 1'b0;
        end
        else if (take_b)
        begin
            state <= tx_b_last ? ARB_IDLE : ARB_HOLD_B;
            b_won_last <= 1'b1;
        end
    end

    always_ff @(posedge afu_csr_axi_lite_if)
    begin
        if (rst)
            arb_valid <= 1'b0;
        else if (take_a || take_b)
            arb_valid <= 1'b1;
        else if (arb_ready)
            arb_valid <= 1'b0;
    end

    // Payload is loaded only on a transfer and needs no reset
    always_ff @(posedge afu_csr_axi_lite_if)
    begin
        if (take_a || take_b)
        begin
            arb_data <= sel_a ? tx_a_data : tx_b_data;
            arb_last <= sel_a ? tx_a_last : tx_b_last;
        end
    end

    // A stalled output beat must stay offered
    a_arb_hold: assert property (@(posedge afu_csr_axi_lite_if) disable iff (rst)
        arb_valid && !arb_ready |=> arb_valid);

    // The locked input excludes the other one for the whole packet
    a_lock_excl: assert property (@(posedge afu_csr_axi_lite_if) disable iff (rst)
        (state == ARB_HOLD_A |-> !tx_b_ready) and (state == ARB_HOLD_B |-> !tx_a_ready));

endmodule

// File: logic/pcie_ss_tx_top.sv
/* TX side of one emulated PCIe SS port. TX A and TX B are merged,
   then sent to the host port while writes raise commits on RX B */
module pcie_ss_tx_top
(
    input  logic                            afu_csr_axi_lite_if,
    input  logic                            rst,

    input  logic                            tx_a_valid,
    output logic                            tx_a_ready,
    input  logic [tlp_pkg::TLP_DATA_W-1:0]  tx_a_data,
    input  logic                            tx_a_last,

    input  logic                            tx_b_valid,
    output logic                            tx_b_ready,
    input  logic [tlp_pkg::TLP_DATA_W-1:0]  tx_b_data,
    input  logic                            tx_b_last,

    output logic                            host_tx_valid,
    input  logic                            host_tx_ready,
    output logic [tlp_pkg::TLP_DATA_W-1:0]  host_tx_data,
    output logic                            host_tx_last,

    output logic                            commit_valid,
    input  logic                            commit_ready,
    output logic [tlp_pkg::TLP_DATA_W-1:0]  commit_data,
    output logic                            commit_last
);
    import tlp_pkg::*;

    // Merged stream between the two pipeline stages
    logic                   arb_valid;
    logic                   arb_ready;
    logic [TLP_DATA_W-1:0]  arb_data;
    logic                   arb_last;

    // First stage picks one input per packet
    tx_ab_arbiter u_tx_ab_arbiter
    (
        .afu_csr_axi_lite_if (afu_csr_axi_lite_if),
        .rst                 (rst),
        .tx_a_valid          (tx_a_valid),
        .tx_a_ready          (tx_a_ready),
        .tx_a_data           (tx_a_data),
        .tx_a_last           (tx_a_last),
        .tx_b_valid          (tx_b_valid),
        .tx_b_ready          (tx_b_ready),
        .tx_b_data           (tx_b_data),
        .tx_b_last           (tx_b_last),
        .arb_valid           (arb_valid),
        .arb_ready           (arb_ready),
        .arb_data            (arb_data),
        .arb_last            (arb_last)
    );

    // Second stage adds one cycle and generates the write commits
    local_commit u_local_commit
    (
        .afu_csr_axi_lite_if (afu_csr_axi_lite_if),
        .rst                 (rst),
        .arb_valid           (arb_valid),
        .arb_ready           (arb_ready),
        .arb_data            (arb_data),
        .arb_last            (arb_last),
        .host_tx_valid       (host_tx_valid),
        .host_tx_ready       (host_tx_ready),
        .host_tx_data        (host_tx_data),
        .host_tx_last        (host_tx_last),
        .commit_valid        (commit_valid),
        .commit_ready        (commit_ready),
        .commit_data         (commit_data),
        .commit_last         (commit_last)
    );

endmodule

// File: tb/tb_pcie_ss_tx.sv
/* Table-driven testbench for the PCIe SS TX pipeline. Packets from the table are
   fed on TX A and TX B, then checked on the host port and on the commit port */
module tb_pcie_ss_tx;
    import tlp_pkg::*;

    localparam int N_ROWS = 28;

    // Columns per row: group, channel (0 = A, 1 = B), opcode, tag, beats
    localparam logic [31:0] PKT_TABLE [N_ROWS] = '{
        32'h0_0_40_01_03, 32'h0_1_40_11_02, 32'h0_0_00_02_01, 32'h0_1_4a_12_03,
        32'h0_0_4a_03_02, 32'h0_1_40_13_01, 32'h0_0_40_04_01, 32'h0_1_00_14_01,
        32'h0_0_40_05_02, 32'h0_1_40_15_03, 32'h0_0_00_06_01, 32'h0_1_4a_16_01,
        32'h1_0_40_21_01, 32'h1_1_40_31_01, 32'h1_0_40_22_02, 32'h1_1_40_32_01,
        32'h1_0_40_23_01, 32'h1_1_40_33_02, 32'h1_0_40_24_03, 32'h1_1_40_34_01,
        32'h2_0_00_41_01, 32'h2_1_4a_51_01, 32'h2_0_4a_42_01, 32'h2_1_00_52_01,
        32'h2_0_40_43_01, 32'h2_1_40_53_01, 32'h2_0_00_44_01, 32'h2_1_4a_54_01
    };

    logic afu_csr_axi_lite_if;
    logic rst;
    logic tx_a_valid, tx_a_ready, tx_a_last;
    logic tx_b_valid, tx_b_ready, tx_b_last;
    logic [TLP_DATA_W-1:0] tx_a_data, tx_b_data, host_tx_data, commit_data;
    logic host_tx_valid, host_tx_ready, host_tx_last;
    logic commit_valid, commit_ready, commit_last;

    integer seed;
    // 0 gives random readies, 1 holds commits back, 2 keeps both readies high
    int mode;
    logic alt_check, exp_next, cur_ch, in_pkt;
    int tx_errors, commit_errors, other_errors;
    int cycles, cycle_limit, total_beats;
    // Expected beats are {first, opcode, last, data}
    logic [73:0] exp_a [$];
    logic [73:0] exp_b [$];
    logic [7:0] exp_commit_q [$];
    logic [64:0] got_commit_q [$];

    pcie_ss_tx_top uut
    (
        .afu_csr_axi_lite_if (afu_csr_axi_lite_if), .rst (rst),
        .tx_a_valid (tx_a_valid), .tx_a_ready (tx_a_ready),
        .tx_a_data (tx_a_data), .tx_a_last (tx_a_last),
        .tx_b_valid (tx_b_valid), .tx_b_ready (tx_b_ready),
        .tx_b_data (tx_b_data), .tx_b_last (tx_b_last),
        .host_tx_valid (host_tx_valid), .host_tx_ready (host_tx_ready),
        .host_tx_data (host_tx_data), .host_tx_last (host_tx_last),
        .commit_valid (commit_valid), .commit_ready (commit_ready),
        .commit_data (commit_data), .commit_last (commit_last)
    );

    always #20 afu_csr_axi_lite_if = ~afu_csr_axi_lite_if;

    // Headers carry the channel in address bit 0 and the table row above it
    function automatic logic [TLP_DATA_W-1:0] beat_data(input int idx, input int b);
        logic [31:0] row;
        logic [7:0] tag;
        row = PKT_TABLE[idx];
        tag = row[15:8];
        if (b == 0)
            return {row[23:16], tag, 40'(idx), 7'h0, row[24]};
        else
            return {tag, 8'(b), 16'hda7a, ~tag, 8'(b), 16'h0f0f};
    endfunction

    task automatic check_tx_beat(input tlp_op_e op, input logic [TLP_DATA_W-1:0] exp_data,
                                 input logic exp_last);
        if (host_tx_data !== exp_data || host_tx_last !== exp_last)
        begin
            tx_errors++;
            $display("[ERROR] %0t: host_tx %s beat %h last %b, expected %h last %b", $time,
                     op.name(), host_tx_data, host_tx_last, exp_data, exp_last);
        end
    endtask

    task automatic check_commit(input tlp_op_e exp_op, input logic [TLP_TAG_W-1:0] exp_tag,
                                input logic [TLP_DATA_W-1:0] got_data, input logic got_last);
        tlp_op_e got_op;
        got_op = tlp_op_e'(got_data[HDR_OP_MSB:HDR_OP_LSB]);
        // Everything below the tag must be zero in a commit
        if (got_op !== exp_op || got_data[HDR_TAG_MSB:HDR_TAG_LSB] !== exp_tag ||
            got_data[HDR_ADDR_MSB:HDR_ADDR_LSB] !== '0 || got_last !== 1'b1)
        begin
            commit_errors++;
            $display("[ERROR] %0t: commit %h last %b, expected %s with tag %h", $time,
                     got_data, got_last, exp_op.name(), exp_tag);
        end
    endtask

    // Queues the expected host beats of one group on their own channel
    task automatic load_expected(input int grp);
        logic [31:0] row;
        int len;
        for (int i = 0; i < N_ROWS; i++)
        begin
            row = PKT_TABLE[i];
            len = int'(row[7:0]);
            if (int'(row[31:28]) == grp)
            begin
                for (int b = 0; b < len; b++)
                begin
                    if (row[24])
                        exp_b.push_back({b == 0, row[23:16], b == len - 1, beat_data(i, b)});
                    else
                        exp_a.push_back({b == 0, row[23:16], b == len - 1, beat_data(i, b)});
                end
            end
        end
    endtask

    // Sends every packet of one group that belongs to one channel
    task automatic feed_channel(input bit ch, input int grp);
        logic [31:0] row;
        int len;
        for (int i = 0; i < N_ROWS; i++)
        begin
            row = PKT_TABLE[i];
            len = int'(row[7:0]);
            if (int'(row[31:28]) == grp && row[24] == ch)
            begin
                for (int b = 0; b < len; b++)
                begin
                    if (ch)
                    begin
                        tx_b_valid <= 1'b1;
                        tx_b_data <= beat_data(i, b);
                        tx_b_last <= (b == len - 1);
                    end
                    else
                    begin
                        tx_a_valid <= 1'b1;
                        tx_a_data <= beat_data(i, b);
                        tx_a_last <= (b == len - 1);
                    end
                    do
                        @(posedge afu_csr_axi_lite_if);
                    while (!(ch ? (tx_b_valid && tx_b_ready) : (tx_a_valid && tx_a_ready)));
                end
            end
        end
        if (ch)
            tx_b_valid <= 1'b0;
        else
            tx_a_valid <= 1'b0;
    endtask

    // Waits until every expected host beat and commit has been seen
    task automatic wait_drain();
        @(negedge afu_csr_axi_lite_if);
        while (exp_a.size() != 0 || exp_b.size() != 0 || exp_commit_q.size() != 0)
            @(negedge afu_csr_axi_lite_if);
    endtask

    always @(posedge afu_csr_axi_lite_if)
    begin
        case (mode)
            0:
            begin
                host_tx_ready <= ($random(seed) & 3) != 0;
                commit_ready <= ($random(seed) & 1) != 0;
            end
            1:
            begin
                host_tx_ready <= 1'b1;
                commit_ready <= 1'b0;
            end
            default:
            begin
                host_tx_ready <= 1'b1;
                commit_ready <= 1'b1;
            end
        endcase
    end

    always @(posedge afu_csr_axi_lite_if)
    begin : scoreboard
        logic [73:0] e;
        logic [64:0] g;
        if (!rst && host_tx_valid && host_tx_ready)
        begin
            // The channel of a packet is known from its header only
            if (!in_pkt)
                cur_ch = host_tx_data[0];
            if ((cur_ch ? exp_b.size() : exp_a.size()) == 0)
            begin
                tx_errors++;
                $display("[ERROR] %0t: unexpected beat %h on host_tx", $time, host_tx_data);
                in_pkt = !host_tx_last;
            end
            else
            begin
                if (cur_ch)
                    e = exp_b.pop_front();
                else
                    e = exp_a.pop_front();
                check_tx_beat(tlp_op_e'(e[72:65]), e[63:0], e[64]);
                in_pkt = !e[64];
                if (e[73])
                begin
                    if (tlp_op_e'(e[72:65]) == OP_MEM_WR)
                        exp_commit_q.push_back(e[55:48]);
                    if (alt_check && cur_ch != exp_next)
                    begin
                        other_errors++;
                        $display("[ERROR] %0t: header from channel %0d breaks alternation",
                                 $time, cur_ch);
                    end
                    // At a loaded boundary the other channel must win next
                    exp_next = !cur_ch;
                end
            end
        end
        if (!rst && commit_valid && commit_ready)
            got_commit_q.push_back({commit_last, commit_data});
        // A commit may leave before its header, so match in order once both exist
        while (exp_commit_q.size() != 0 && got_commit_q.size() != 0)
        begin
            g = got_commit_q.pop_front();
            check_commit(OP_COMMIT, exp_commit_q.pop_front(), g[63:0], g[64]);
        end
    end

    always @(posedge afu_csr_axi_lite_if)
    begin
        cycles++;
        if (cycles >= cycle_limit)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("Beats still expected: TX A %0d, TX B %0d", exp_a.size(), exp_b.size());
            $display("Commits still expected %0d, unmatched commits seen %0d",
                     exp_commit_q.size(), got_commit_q.size());
            $display("Result: FAILED");
            $finish;
        end
    end

    initial
    begin
        logic [31:0] row;
        seed = 41;
        afu_csr_axi_lite_if = 1'b0;
        rst = 1'b1;
        {tx_a_valid, tx_a_last, tx_b_valid, tx_b_last} = '0;
        tx_a_data = '0;
        tx_b_data = '0;
        host_tx_ready = 1'b0;
        commit_ready = 1'b0;
        mode = 0;
        {alt_check, exp_next, cur_ch, in_pkt} = '0;
        {tx_errors, commit_errors, other_errors, cycles, total_beats} = '0;
        for (int i = 0; i < N_ROWS; i++)
        begin
            row = PKT_TABLE[i];
            total_beats += int'(row[7:0]);
        end
        cycle_limit = total_beats * 40 + 200;

        repeat (8) @(posedge afu_csr_axi_lite_if);
        rst <= 1'b0;
        @(negedge afu_csr_axi_lite_if);
        if (host_tx_valid || commit_valid || tx_a_ready || tx_b_ready || uut.arb_valid)
        begin
            other_errors++;
            $display("[ERROR] %0t: outputs not low after reset", $time);
        end

        // Mixed traffic on both channels under random back-pressure
        load_expected(0);
        @(posedge afu_csr_axi_lite_if);
        fork
            feed_channel(1'b0, 0);
            feed_channel(1'b1, 0);
        join
        wait_drain();

        // Burst of writes while the commit port is held off
        load_expected(1);
        @(posedge afu_csr_axi_lite_if);
        mode <= 1;
        fork
            feed_channel(1'b0, 1);
            feed_channel(1'b1, 1);
            begin
                repeat (40) @(posedge afu_csr_axi_lite_if);
                @(negedge afu_csr_axi_lite_if);
                if (!commit_valid || exp_a.size() + exp_b.size() == 0)
                begin
                    other_errors++;
                    $display("[ERROR] %0t: write burst did not stall on a full FIFO", $time);
                end
                @(posedge afu_csr_axi_lite_if);
                mode <= 2;
            end
        join
        wait_drain();

        // One-beat packets on both channels with both readies high
        load_expected(2);
        @(posedge afu_csr_axi_lite_if);
        alt_check <= 1'b1;
        fork
            feed_channel(1'b0, 2);
            feed_channel(1'b1, 2);
        join
        wait_drain();
        repeat (10) @(negedge afu_csr_axi_lite_if);

        if (got_commit_q.size() != 0 || commit_valid)
        begin
            commit_errors++;
            $display("[ERROR] %0t: %0d extra commit beats seen", $time, got_commit_q.size());
        end
        $display("Errors: host_tx %0d, commit %0d, other %0d",
                 tx_errors, commit_errors, other_errors);
        if (tx_errors + commit_errors + other_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: files.f
common/tlp_pkg.sv
common/emul_cfg_pkg.sv
local_commit/commit_fifo.sv
local_commit/local_commit.sv
logic/tx_ab_arbiter.sv
logic/pcie_ss_tx_top.sv
tb/tb_pcie_ss_tx.sv

// File: Makefile
# Verilator simulation of the PCIe SS TX pipeline

VERILATOR ?= verilator
TOP       ?= tb_pcie_ss_tx
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Result: FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
